/* source/egress_qs_pkg.sv */
`default_nettype none

package egress_qs_pkg;

    // Stream beat
    localparam int DATA_WID     = 32;
    localparam int DEST_WID     = 2;

    // Buffer geometry, address is {pointer, beat index}
    localparam int NUM_BUFFERS  = 8;
    localparam int BUF_BEATS    = 8;
    localparam int PTR_WID      = 3;
    localparam int LEN_WID      = 4;
    localparam int MEM_ADDR_WID = 6;

    // At least NUM_BUFFERS so the push side never sees a full FIFO
    localparam int DESC_DEPTH   = 8;

    localparam int DROP_CNT_WID = 8;

    typedef struct packed {
        logic [PTR_WID-1:0]  ptr;
        logic [LEN_WID-1:0]  len;
        logic [DEST_WID-1:0] dest;
    } desc_t;

    typedef enum logic [1:0] {
        W_IDLE,
        W_DATA,
        W_DISCARD
    } wr_state_e;

    typedef enum logic {
        R_IDLE,
        R_READ
    } rd_state_e;

endpackage

`default_nettype wire

/* source/stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Packet stream, one beat per valid/ready handshake
interface stream_if;
    import egress_qs_pkg::*;

    logic                valid;
    logic                ready;
    logic [DATA_WID-1:0] data;
    logic                last;
    logic [DEST_WID-1:0] dest;

    modport src (output valid, data, last, dest, input ready);
    modport dst (input valid, data, last, dest, output ready);

endinterface

`default_nettype wire

/* source/egress_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module egress_ctrl (
    input  logic                                   clk,
    input  logic                                   i_arst_n,
    input  logic                                   i_soft_reset,
    input  logic                                   i_enable,
    input  logic                                   i_drop_clear,
    input  logic                                   i_drop,
    input  logic                                   i_in_valid,
    output logic                                   o_in_ready,
    input  logic [egress_qs_pkg::DATA_WID-1:0]     i_in_data,
    input  logic                                   i_in_last,
    input  logic [egress_qs_pkg::DEST_WID-1:0]     i_in_dest,
    output logic                                   o_out_valid,
    input  logic                                   i_out_ready,
    output logic [egress_qs_pkg::DATA_WID-1:0]     o_out_data,
    output logic                                   o_out_last,
    output logic [egress_qs_pkg::DEST_WID-1:0]     o_out_dest,
    stream_if.src                                  q_in,
    stream_if.dst                                  q_out,
    output logic                                   o_local_rst,
    output logic [egress_qs_pkg::DROP_CNT_WID-1:0] o_drop_count
);
    import egress_qs_pkg::*;

    logic                bypass;
    logic                byp_room;
    logic                byp_valid;
    logic [DATA_WID-1:0] byp_data;
    logic                byp_last;
    logic [DEST_WID-1:0] byp_dest;

    // --------------------
    // Local reset
    // --------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_local_rst <= 1'b1;
        end else begin
            o_local_rst <= i_soft_reset;
        end
    end

    // --------------------
    // Bypass stage
    // --------------------
    assign bypass   = !i_enable;
    assign byp_room = !byp_valid || i_out_ready;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            byp_valid <= 1'b0;
        end else if (o_local_rst) begin
            byp_valid <= 1'b0;
        end else if (byp_room) begin
            byp_valid <= i_in_valid && bypass;
        end
    end

    always_ff @(posedge clk) begin
        if (byp_room && i_in_valid) begin
            byp_data <= i_in_data;
            byp_last <= i_in_last;
            byp_dest <= i_in_dest;
        end
    end

    // Queue path, the writer never stalls in queue mode
    assign q_in.valid  = i_in_valid && !bypass;
    assign q_in.data   = i_in_data;
    assign q_in.last   = i_in_last;
    assign q_in.dest   = i_in_dest;
    assign q_out.ready = i_out_ready && !bypass;

    assign o_in_ready  = bypass ? byp_room  : q_in.ready;
    assign o_out_valid = bypass ? byp_valid : q_out.valid;
    assign o_out_data  = bypass ? byp_data  : q_out.data;
    assign o_out_last  = bypass ? byp_last  : q_out.last;
    assign o_out_dest  = bypass ? byp_dest  : q_out.dest;

    // Saturating drop count
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_drop_count <= '0;
        end else if (o_local_rst || i_drop_clear) begin
            o_drop_count <= '0;
        end else if (i_drop && (o_drop_count != '1)) begin
            o_drop_count <= o_drop_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/buf_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module buf_alloc (
    input  logic                              clk,
    input  logic                              i_arst_n,
    input  logic                              i_local_rst,
    output logic                              o_avail,
    output logic [egress_qs_pkg::PTR_WID-1:0] o_ptr,
    input  logic                              i_take,
    input  logic                              i_free,
    input  logic [egress_qs_pkg::PTR_WID-1:0] i_free_ptr,
    input  logic                              i_free2,
    input  logic [egress_qs_pkg::PTR_WID-1:0] i_free2_ptr,
    output logic                              o_init_done
);
    import egress_qs_pkg::*;

    // Extra index bit tells a full list from an empty one
    logic [PTR_WID-1:0] free_list [NUM_BUFFERS];
    logic [PTR_WID:0]   rd_idx;
    logic [PTR_WID:0]   wr_idx;
    logic [PTR_WID:0]   wr_idx2;

    assign wr_idx2 = wr_idx + (PTR_WID+1)'(i_free);
    assign o_avail = o_init_done && (wr_idx != rd_idx);
    assign o_ptr   = free_list[rd_idx[PTR_WID-1:0]];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_idx      <= '0;
            wr_idx      <= '0;
            o_init_done <= 1'b0;
        end else if (i_local_rst) begin
            rd_idx      <= '0;
            wr_idx      <= '0;
            o_init_done <= 1'b0;
        end else if (!o_init_done) begin
            // Fill with every buffer index, one per cycle
            wr_idx <= wr_idx + 1'b1;
            if (wr_idx == (PTR_WID+1)'(NUM_BUFFERS - 1)) begin
                o_init_done <= 1'b1;
            end
        end else begin
            if (i_take) begin
                rd_idx <= rd_idx + 1'b1;
            end
            wr_idx <= wr_idx2 + (PTR_WID+1)'(i_free2);
        end
    end

    always_ff @(posedge clk) begin
        if (!o_init_done) begin
            free_list[wr_idx[PTR_WID-1:0]] <= wr_idx[PTR_WID-1:0];
        end else begin
            if (i_free) begin
                free_list[wr_idx[PTR_WID-1:0]] <= i_free_ptr;
            end
            if (i_free2) begin
                free_list[wr_idx2[PTR_WID-1:0]] <= i_free2_ptr;
            end
        end
    end

endmodule

`default_nettype wire

/* source/buf_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module buf_mem (
    input  logic                                   clk,
    input  logic                                   i_wr_en,
    input  logic [egress_qs_pkg::MEM_ADDR_WID-1:0] i_wr_addr,
    input  logic [egress_qs_pkg::DATA_WID-1:0]     i_wr_data,
    input  logic [egress_qs_pkg::MEM_ADDR_WID-1:0] i_rd_addr,
    output logic [egress_qs_pkg::DATA_WID-1:0]     o_rd_data
);
    import egress_qs_pkg::*;

    logic [DATA_WID-1:0] mem [2**MEM_ADDR_WID];

    // Read data lands one cycle after the address
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

/* source/pkt_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_writer (
    input  logic                                   clk,
    input  logic                                   i_arst_n,
    input  logic                                   i_local_rst,
    stream_if.dst                                  q_in,
    input  logic                                   i_avail,
    input  logic [egress_qs_pkg::PTR_WID-1:0]      i_ptr,
    output logic                                   o_take,
    output logic                                   o_free,
    output logic [egress_qs_pkg::PTR_WID-1:0]      o_free_ptr,
    output logic                                   o_wr_en,
    output logic [egress_qs_pkg::MEM_ADDR_WID-1:0] o_wr_addr,
    output logic [egress_qs_pkg::DATA_WID-1:0]     o_wr_data,
    output logic                                   o_push,
    output egress_qs_pkg::desc_t                   o_desc,
    output logic                                   o_drop
);
    import egress_qs_pkg::*;

    wr_state_e           state;
    wr_state_e           state_nxt;
    logic                accept;
    logic                beat;
    logic                idle;
    logic                oversize;
    logic [PTR_WID-1:0]  cur_ptr;
    logic [DEST_WID-1:0] cur_dest;
    logic [LEN_WID-1:0]  idx;

    assign q_in.ready = accept;
    assign beat       = q_in.valid && accept;
    assign idle       = (state == W_IDLE);
    assign oversize   = (state == W_DATA) && (idx == LEN_WID'(BUF_BEATS));

    assign o_take     = beat && idle && i_avail;
    assign o_wr_en    = o_take || (beat && (state == W_DATA) && !oversize);
    assign o_wr_addr  = idle ? {i_ptr, {(MEM_ADDR_WID-PTR_WID){1'b0}}}
                             : {cur_ptr, idx[MEM_ADDR_WID-PTR_WID-1:0]};
    assign o_wr_data  = q_in.data;
    assign o_free     = beat && oversize;
    assign o_free_ptr = cur_ptr;
    // One pulse per dropped packet, on its first or its overflow beat
    assign o_drop     = beat && ((idle && !i_avail) || oversize);

    always_comb begin
        state_nxt = state;
        case (state)
            W_IDLE: begin
                if (beat && !q_in.last) begin
                    state_nxt = i_avail ? W_DATA : W_DISCARD;
                end
            end
            W_DATA: begin
                if (beat && q_in.last) begin
                    state_nxt = W_IDLE;
                end else if (beat && oversize) begin
                    state_nxt = W_DISCARD;
                end
            end
            W_DISCARD: begin
                if (beat && q_in.last) begin
                    state_nxt = W_IDLE;
                end
            end
            default: state_nxt = W_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state  <= W_IDLE;
            accept <= 1'b0;
            o_push <= 1'b0;
        end else begin
            accept <= !i_local_rst;
            if (i_local_rst) begin
                state  <= W_IDLE;
                o_push <= 1'b0;
            end else begin
                state  <= state_nxt;
                o_push <= o_wr_en && q_in.last;
            end
        end
    end

    // Descriptor is built alongside each write and pushed a cycle later
    always_ff @(posedge clk) begin
        if (o_take) begin
            cur_ptr  <= i_ptr;
            cur_dest <= q_in.dest;
        end
        if (o_wr_en) begin
            idx <= idle ? LEN_WID'(1) : idx + 1'b1;
        end
        o_desc.ptr  <= idle ? i_ptr : cur_ptr;
        o_desc.len  <= idle ? LEN_WID'(1) : idx + 1'b1;
        o_desc.dest <= idle ? q_in.dest : cur_dest;
    end

endmodule

`default_nettype wire

/* source/desc_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module desc_fifo (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic                 i_local_rst,
    input  logic                 i_push,
    input  egress_qs_pkg::desc_t i_desc,
    input  logic                 i_pop,
    output logic                 o_valid,
    output egress_qs_pkg::desc_t o_desc
);
    import egress_qs_pkg::*;

    desc_t                       entries [DESC_DEPTH];
    logic [$clog2(DESC_DEPTH):0] wr_idx;
    logic [$clog2(DESC_DEPTH):0] rd_idx;

    assign o_valid = (wr_idx != rd_idx);
    assign o_desc  = entries[rd_idx[$clog2(DESC_DEPTH)-1:0]];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_idx <= '0;
            rd_idx <= '0;
        end else if (i_local_rst) begin
            wr_idx <= '0;
            rd_idx <= '0;
        end else begin
            if (i_push) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (i_pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            entries[wr_idx[$clog2(DESC_DEPTH)-1:0]] <= i_desc;
        end
    end

endmodule

`default_nettype wire

/* source/pkt_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_reader (
    input  logic                                   clk,
    input  logic                                   i_arst_n,
    input  logic                                   i_local_rst,
    input  logic                                   i_desc_valid,
    input  egress_qs_pkg::desc_t                   i_desc,
    output logic                                   o_pop,
    output logic [egress_qs_pkg::MEM_ADDR_WID-1:0] o_rd_addr,
    input  logic [egress_qs_pkg::DATA_WID-1:0]     i_rd_data,
    stream_if.src                                  q_out,
    output logic                                   o_free,
    output logic [egress_qs_pkg::PTR_WID-1:0]      o_free_ptr
);
    import egress_qs_pkg::*;

    rd_state_e           state;
    desc_t               cur;
    logic [LEN_WID-1:0]  rd_cnt;
    logic                issue;
    logic                rd_pend;
    logic                pend_last;
    logic                pf_valid;
    logic                pf_last;
    logic [DATA_WID-1:0] pf_data;
    logic                out_valid;
    logic                out_last;
    logic [DATA_WID-1:0] out_data;
    logic                out_xfer;
    logic                out_free;
    logic [1:0]          slots;

    assign out_xfer = out_valid && q_out.ready;
    assign out_free = !out_valid || q_out.ready;

    // Words held or in flight after this edge, at most one more may be issued
    assign slots = 2'(out_valid) + 2'(pf_valid) + 2'(rd_pend) - 2'(out_xfer);
    assign issue = (state == R_READ) && (rd_cnt != cur.len) && (slots <= 2'd1);

    assign o_pop      = (state == R_IDLE) && i_desc_valid;
    assign o_rd_addr  = {cur.ptr, rd_cnt[MEM_ADDR_WID-PTR_WID-1:0]};
    assign o_free     = out_xfer && out_last;
    assign o_free_ptr = cur.ptr;

    assign q_out.valid = out_valid;
    assign q_out.data  = out_data;
    assign q_out.last  = out_last;
    assign q_out.dest  = cur.dest;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state     <= R_IDLE;
            rd_cnt    <= '0;
            rd_pend   <= 1'b0;
            pf_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (i_local_rst) begin
            state     <= R_IDLE;
            rd_cnt    <= '0;
            rd_pend   <= 1'b0;
            pf_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            rd_pend <= issue;
            if (o_pop) begin
                state  <= R_READ;
                rd_cnt <= '0;
            end else if (o_free) begin
                state <= R_IDLE;
            end
            if (issue) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (out_free) begin
                out_valid <= pf_valid || rd_pend;
                pf_valid  <= pf_valid && rd_pend;
            end else if (rd_pend) begin
                pf_valid <= 1'b1;
            end
        end
    end

    // Memory word goes to the output if it is free, else to the prefetch register
    always_ff @(posedge clk) begin
        if (o_pop) begin
            cur <= i_desc;
        end
        if (issue) begin
            pend_last <= (rd_cnt == cur.len - 1'b1);
        end
        if (out_free) begin
            out_data <= pf_valid ? pf_data : i_rd_data;
            out_last <= pf_valid ? pf_last : pend_last;
        end
        if (rd_pend && (pf_valid || !out_free)) begin
            pf_data <= i_rd_data;
            pf_last <= pend_last;
        end
    end

endmodule

`default_nettype wire

/* source/egress_qs_top.sv */
`timescale 1ns/1ps
`default_nettype none

module egress_qs_top (
    input  logic                                   clk,
    input  logic                                   i_arst_n,
    input  logic                                   i_soft_reset,
    input  logic                                   i_enable,
    input  logic                                   i_drop_clear,
    input  logic                                   i_in_valid,
    output logic                                   o_in_ready,
    input  logic [egress_qs_pkg::DATA_WID-1:0]     i_in_data,
    input  logic                                   i_in_last,
    input  logic [egress_qs_pkg::DEST_WID-1:0]     i_in_dest,
    output logic                                   o_out_valid,
    input  logic                                   i_out_ready,
    output logic [egress_qs_pkg::DATA_WID-1:0]     o_out_data,
    output logic                                   o_out_last,
    output logic [egress_qs_pkg::DEST_WID-1:0]     o_out_dest,
    output logic                                   o_init_done,
    output logic [egress_qs_pkg::DROP_CNT_WID-1:0] o_drop_count
);
    import egress_qs_pkg::*;

    logic                    local_rst;
    logic                    drop;
    logic                    avail;
    logic                    take;
    logic [PTR_WID-1:0]      alloc_ptr;
    logic                    wr_free;
    logic [PTR_WID-1:0]      wr_free_ptr;
    logic                    rd_free;
    logic [PTR_WID-1:0]      rd_free_ptr;
    logic                    mem_wr_en;
    logic [MEM_ADDR_WID-1:0] mem_wr_addr;
    logic [DATA_WID-1:0]     mem_wr_data;
    logic [MEM_ADDR_WID-1:0] mem_rd_addr;
    logic [DATA_WID-1:0]     mem_rd_data;
    logic                    push;
    desc_t                   push_desc;
    logic                    pop;
    logic                    desc_valid;
    desc_t                   head_desc;

    stream_if q_in ();
    stream_if q_out ();

    egress_ctrl u_ctrl (
        .clk,
        .i_arst_n,
        .i_soft_reset,
        .i_enable,
        .i_drop_clear,
        .i_drop       (drop),
        .i_in_valid,
        .o_in_ready,
        .i_in_data,
        .i_in_last,
        .i_in_dest,
        .o_out_valid,
        .i_out_ready,
        .o_out_data,
        .o_out_last,
        .o_out_dest,
        .q_in         (q_in),
        .q_out        (q_out),
        .o_local_rst  (local_rst),
        .o_drop_count
    );

    // Reader frees on port 1, writer returns oversize buffers on port 2
    buf_alloc u_alloc (
        .clk,
        .i_arst_n,
        .i_local_rst (local_rst),
        .o_avail     (avail),
        .o_ptr       (alloc_ptr),
        .i_take      (take),
        .i_free      (rd_free),
        .i_free_ptr  (rd_free_ptr),
        .i_free2     (wr_free),
        .i_free2_ptr (wr_free_ptr),
        .o_init_done
    );

    buf_mem u_mem (
        .clk,
        .i_wr_en   (mem_wr_en),
        .i_wr_addr (mem_wr_addr),
        .i_wr_data (mem_wr_data),
        .i_rd_addr (mem_rd_addr),
        .o_rd_data (mem_rd_data)
    );

    pkt_writer u_writer (
        .clk,
        .i_arst_n,
        .i_local_rst (local_rst),
        .q_in        (q_in),
        .i_avail     (avail),
        .i_ptr       (alloc_ptr),
        .o_take      (take),
        .o_free      (wr_free),
        .o_free_ptr  (wr_free_ptr),
        .o_wr_en     (mem_wr_en),
        .o_wr_addr   (mem_wr_addr),
        .o_wr_data   (mem_wr_data),
        .o_push      (push),
        .o_desc      (push_desc),
        .o_drop      (drop)
    );

    desc_fifo u_fifo (
        .clk,
        .i_arst_n,
        .i_local_rst (local_rst),
        .i_push      (push),
        .i_desc      (push_desc),
        .i_pop       (pop),
        .o_valid     (desc_valid),
        .o_desc      (head_desc)
    );

    pkt_reader u_reader (
        .clk,
        .i_arst_n,
        .i_local_rst  (local_rst),
        .i_desc_valid (desc_valid),
        .i_desc       (head_desc),
        .o_pop        (pop),
        .o_rd_addr    (mem_rd_addr),
        .i_rd_data    (mem_rd_data),
        .q_out        (q_out),
        .o_free       (rd_free),
        .o_free_ptr   (rd_free_ptr)
    );

endmodule

`default_nettype wire

/* dv/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic o_arst_n
);
    localparam real HALF_PERIOD_NS = 5.0;
    localparam int  RESET_CYCLES   = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Reset released on a falling edge, away from the flops
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        o_arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/egress_qs_props.sv */
`timescale 1ns/1ps
`default_nettype none

module egress_qs_props (
    input logic                                   clk,
    input logic                                   i_arst_n,
    input logic                                   i_soft_reset,
    input logic                                   i_drop_clear,
    input logic                                   o_out_valid,
    input logic                                   i_out_ready,
    input logic [egress_qs_pkg::DATA_WID-1:0]     o_out_data,
    input logic                                   o_out_last,
    input logic [egress_qs_pkg::DEST_WID-1:0]     o_out_dest,
    input logic [egress_qs_pkg::DROP_CNT_WID-1:0] o_drop_count
);

    // Stalled beat holds until it transfers
    a_out_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_out_valid && !i_out_ready) |=>
            (o_out_valid && $stable(o_out_data) && $stable(o_out_last) && $stable(o_out_dest)))
    else $error("output beat changed while stalled by back-pressure");

    a_reset_idle: assert property (@(posedge clk) !i_arst_n |-> !o_out_valid)
    else $error("output valid high during reset");

    // Soft reset reaches the counter through the local reset register
    a_drop_monotonic: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_drop_count < $past(o_drop_count)) |-> ($past(i_drop_clear) || $past(i_soft_reset, 2)))
    else $error("drop count decreased without a clear or a reset");

endmodule

`default_nettype wire

/* dv/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import egress_qs_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h1ad3_4122;
    localparam int N_QUEUE        = 8;
    localparam int N_BACKPRESSURE = 8;
    localparam int N_BYPASS       = 6;
    // Every test packet, counted at its largest size, with slack for stalls
    localparam int TOTAL_PKTS     = N_QUEUE + N_BACKPRESSURE + (NUM_BUFFERS + 1) + 2
                                    + (N_BYPASS + 1) + 2;
    localparam int TIMEOUT_CYCLES = TOTAL_PKTS * (BUF_BEATS + 1) * 8 + 500;

    logic                    clk;
    logic                    arst_n;
    logic                    i_soft_reset;
    logic                    i_enable;
    logic                    i_drop_clear;
    logic                    i_in_valid;
    logic                    o_in_ready;
    logic [DATA_WID-1:0]     i_in_data;
    logic                    i_in_last;
    logic [DEST_WID-1:0]     i_in_dest;
    logic                    o_out_valid;
    logic                    i_out_ready;
    logic [DATA_WID-1:0]     o_out_data;
    logic                    o_out_last;
    logic [DEST_WID-1:0]     o_out_dest;
    logic                    o_init_done;
    logic [DROP_CNT_WID-1:0] o_drop_count;

    logic [31:0]             lfsr_state = LFSR_SEED;
    bit                      bp_random;
    bit                      ready_level;
    logic [DROP_CNT_WID-1:0] exp_drops;
    int                      cycle_cnt;

    // Beats expected at the output, in order
    logic [DATA_WID-1:0]     exp_data_q [$];
    logic                    exp_last_q [$];
    logic [DEST_WID-1:0]     exp_dest_q [$];

    tb_clkgen u_clkgen (
        .clk,
        .o_arst_n (arst_n)
    );

    egress_qs_top uut (
        .clk,
        .i_arst_n (arst_n),
        .i_soft_reset,
        .i_enable,
        .i_drop_clear,
        .i_in_valid,
        .o_in_ready,
        .i_in_data,
        .i_in_last,
        .i_in_dest,
        .o_out_valid,
        .i_out_ready,
        .o_out_data,
        .o_out_last,
        .o_out_dest,
        .o_init_done,
        .o_drop_count
    );

    bind egress_qs_top egress_qs_props u_props (.*);

    // --------------------
    // Random source
    // --------------------
    // Taps 32, 22, 2, 1
    function automatic logic random_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], random_bit()};
        end
        return value;
    endfunction

    // --------------------
    // Checks
    // --------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_beat(
        input logic [DATA_WID-1:0] got_data,
        input logic [DATA_WID-1:0] want_data,
        input logic                got_last,
        input logic                want_last,
        input logic [DEST_WID-1:0] got_dest,
        input logic [DEST_WID-1:0] want_dest
    );
        if (got_data !== want_data) begin
            abort_run($sformatf("error: o_out_data is 0x%h, expected 0x%h", got_data, want_data));
        end
        if (got_last !== want_last) begin
            abort_run($sformatf("error: o_out_last is 0x%h, expected 0x%h", got_last, want_last));
        end
        if (got_dest !== want_dest) begin
            abort_run($sformatf("error: o_out_dest is 0x%h, expected 0x%h", got_dest, want_dest));
        end
    endtask

    task automatic check_drop_count(
        input logic [DROP_CNT_WID-1:0] got,
        input logic [DROP_CNT_WID-1:0] want
    );
        if (got !== want) begin
            abort_run($sformatf("error: o_drop_count is 0x%h, expected 0x%h", got, want));
        end
    endtask

    // Output monitor, a beat moves on the next rising edge
    always @(negedge clk) begin
        if (arst_n && o_out_valid && i_out_ready) begin
            if (exp_data_q.size() == 0) begin
                abort_run("an output beat appeared with no packet outstanding");
            end else begin
                check_beat(o_out_data, exp_data_q.pop_front(), o_out_last,
                           exp_last_q.pop_front(), o_out_dest, exp_dest_q.pop_front());
            end
        end
    end

    // Output back-pressure, random or held at a level
    initial begin : out_ready_drive
        logic ready_next;
        i_out_ready = 1'b1;
        forever begin
            @(negedge clk);
            ready_next = bp_random ? random_bit() : ready_level;
            @(posedge clk);
            i_out_ready <= ready_next;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        abort_run($sformatf("timeout: the tests did not end within %0d cycles", TIMEOUT_CYCLES));
    end

    // --------------------
    // Stimulus helpers
    // --------------------
    task automatic send_packet(
        input int                  len,
        input logic [DEST_WID-1:0] dest,
        input bit                  expect_out
    );
        logic [DATA_WID-1:0] data;
        logic                last;
        logic                accepted;
        for (int b = 0; b < len; b++) begin
            data = rand_bits(DATA_WID);
            last = (b == len - 1);
            if (expect_out) begin
                exp_data_q.push_back(data);
                exp_last_q.push_back(last);
                exp_dest_q.push_back(dest);
            end
            i_in_valid <= 1'b1;
            i_in_data  <= data;
            i_in_last  <= last;
            i_in_dest  <= dest;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = o_in_ready;
                @(posedge clk);
            end
        end
        i_in_valid <= 1'b0;
    endtask

    // Length 0 picks 1 to BUF_BEATS beats
    task automatic send_random_packet(input int len, input bit expect_out);
        int                  n;
        logic [DEST_WID-1:0] dest;
        @(posedge clk);
        n    = (len == 0) ? int'(rand_bits($clog2(BUF_BEATS))) + 1 : len;
        dest = rand_bits(DEST_WID);
        send_packet(n, dest, expect_out);
    endtask

    task automatic wait_drain();
        while (exp_data_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic wait_init_done();
        @(negedge clk);
        while (!o_init_done) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic check_drops();
        @(negedge clk);
        check_drop_count(o_drop_count, exp_drops);
        @(posedge clk);
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_queue_order();
        wait_init_done();
        for (int i = 0; i < N_QUEUE; i++) begin
            send_random_packet(0, 1'b1);
        end
        wait_drain();
        check_drops();
    endtask

    task automatic test_backpressure();
        bp_random = 1'b1;
        for (int i = 0; i < N_BACKPRESSURE; i++) begin
            send_random_packet(0, 1'b1);
        end
        wait_drain();
        bp_random = 1'b0;
        check_drops();
    endtask

    // Stalled output keeps all buffers busy, the last packet finds none
    task automatic test_buffer_exhaustion();
        ready_level = 1'b0;
        @(posedge clk);
        for (int i = 0; i <= NUM_BUFFERS; i++) begin
            send_random_packet(0, i < NUM_BUFFERS);
        end
        exp_drops = exp_drops + 1'b1;
        repeat (2) @(posedge clk);
        check_drops();
        ready_level = 1'b1;
        wait_drain();
    endtask

    task automatic test_oversize();
        send_random_packet(BUF_BEATS + 1, 1'b0);
        exp_drops = exp_drops + 1'b1;
        repeat (2) @(posedge clk);
        check_drops();
        i_drop_clear <= 1'b1;
        @(posedge clk);
        i_drop_clear <= 1'b0;
        exp_drops = '0;
        check_drops();
        // A leaked oversize packet would show up ahead of this one
        send_random_packet(0, 1'b1);
        wait_drain();
    endtask

    task automatic test_bypass();
        i_enable <= 1'b0;
        bp_random = 1'b1;
        for (int i = 0; i < N_BYPASS; i++) begin
            send_random_packet(0, 1'b1);
        end
        // Longer than a buffer, still passes since the bypass stores nothing
        send_random_packet(BUF_BEATS + 1, 1'b1);
        wait_drain();
        bp_random = 1'b0;
        @(posedge clk);
        i_enable <= 1'b1;
        check_drops();
    endtask

    task automatic test_soft_reset();
        // A drop ahead of the pulse leaves a count for the reset to clear
        send_random_packet(BUF_BEATS + 1, 1'b0);
        exp_drops = exp_drops + 1'b1;
        check_drops();
        @(posedge clk);
        i_soft_reset <= 1'b1;
        @(posedge clk);
        i_soft_reset <= 1'b0;
        @(negedge clk);
        while (o_init_done) begin
            @(negedge clk);
        end
        exp_drops = '0;
        wait_init_done();
        check_drops();
        send_random_packet(0, 1'b1);
        wait_drain();
        check_drops();
    endtask

    initial begin
        i_soft_reset = 1'b0;
        i_enable     = 1'b1;
        i_drop_clear = 1'b0;
        i_in_valid   = 1'b0;
        i_in_data    = '0;
        i_in_last    = 1'b0;
        i_in_dest    = '0;
        bp_random    = 1'b0;
        ready_level  = 1'b1;
        exp_drops    = '0;
        @(posedge clk);
        while (!arst_n) begin
            @(posedge clk);
        end

        test_queue_order();
        test_backpressure();
        test_buffer_exhaustion();
        test_oversize();
        test_bypass();
        test_soft_reset();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/egress_qs_pkg.sv
source/stream_if.sv
source/egress_ctrl.sv
source/buf_alloc.sv
source/buf_mem.sv
source/pkt_writer.sv
source/desc_fifo.sv
source/pkt_reader.sv
source/egress_qs_top.sv
dv/tb_clkgen.sv
dv/egress_qs_props.sv
dv/tb_top.sv

/* Bender.yml */
package:
  name: egress_qs

sources:
  - source/egress_qs_pkg.sv
  - source/stream_if.sv
  - source/egress_ctrl.sv
  - source/buf_alloc.sv
  - source/buf_mem.sv
  - source/pkt_writer.sv
  - source/desc_fifo.sv
  - source/pkt_reader.sv
  - source/egress_qs_top.sv
  - target: test
    files:
      - dv/tb_clkgen.sv
      - dv/egress_qs_props.sv
      - dv/tb_top.sv
